// ==== mpa_pkg.sv ====
package mpa_pkg;

    localparam int DATA_W = 32;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [DATA_W-1:0] instr_t;  // Kept apart from word_t so RAM payloads read clearly
    typedef logic [4:0]        reg_addr_t;

    localparam int IM_DEPTH  = 32;
    localparam int DM_DEPTH  = 32;
    localparam int IM_AW     = $clog2(IM_DEPTH);
    localparam int DM_AW     = $clog2(DM_DEPTH);
    localparam int REG_COUNT = 32;

    localparam word_t RESET_PC = '0;
    localparam word_t PC_STEP  = 4;

    // Opcode field, instr[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // Funct field of SPECIAL, instr[5:0]
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_NOR, ALU_SLL, ALU_SRL, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [1:0] {IMM_NONE, IMM_SIGN, IMM_ZERO} imm_ext_e;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LUI} wb_sel_e;

    // debug_func codes, 0 selects nothing
    localparam logic [1:0] DBG_IM = 2'd1;
    localparam logic [1:0] DBG_DM = 2'd2;
    localparam logic [1:0] DBG_MR = 2'd3;

endpackage

// ==== mpa_word_ram.sv ====
`timescale 1ns/1ns

module mpa_word_ram #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 32
) (
    input  logic                     mem_debug_clk_gate,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    input  payload_t                 wdata,
    output payload_t                 rdata
);

    payload_t mem [DEPTH];

    // Asynchronous read port
    assign rdata = mem[raddr];

    always_ff @(posedge mem_debug_clk_gate) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Only matters for depths that are not a power of two
    a_waddr_in_range: assert property (
        @(posedge mem_debug_clk_gate) we |-> (int'(waddr) < DEPTH)
    ) else $error("word ram write index %0d beyond depth %0d", waddr, DEPTH);

endmodule

// ==== mpa_fetch.sv ====
`timescale 1ns/1ns

module mpa_fetch import mpa_pkg::*; (
    input  logic   mem_debug_clk_gate,
    input  logic   HW_RSTn,
    input  logic   mem_debug,
    input  logic   im_dbg_we,
    input  word_t  addr,
    input  word_t  din,
    output instr_t instr
);

    word_t            pc;
    logic [IM_AW-1:0] im_raddr;

    // PC parks at the reset address for the whole debug session
    always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
        if (!HW_RSTn) begin
            pc <= RESET_PC;
        end else if (mem_debug) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc + PC_STEP;
        end
    end

    // Byte address to word index
    assign im_raddr = mem_debug ? addr[IM_AW+1:2] : pc[IM_AW+1:2];

    mpa_word_ram #(
        .payload_t (instr_t),
        .DEPTH     (IM_DEPTH)
    ) i_imem (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .we                 (im_dbg_we),           // Only the debug port loads programs
        .waddr              (addr[IM_AW+1:2]),
        .raddr              (im_raddr),
        .wdata              (instr_t'(din)),
        .rdata              (instr)
    );

endmodule

// ==== mpa_decode.sv ====
`timescale 1ns/1ns

module mpa_decode import mpa_pkg::*; (
    input  instr_t    instr,
    input  logic      mem_debug,
    input  word_t     addr,
    output reg_addr_t rs_addr,
    output reg_addr_t rt_addr,
    output reg_addr_t dest_addr,
    output alu_op_e   alu_op,
    output imm_ext_e  imm_ext,
    output logic      shift_sel,
    output logic      reg_we,
    output logic      dm_we,
    output wb_sel_e   wb_sel
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    assign rs_addr   = instr[25:21];
    assign rt_addr   = mem_debug ? addr[4:0] : instr[20:16];  // Debug reads a register via rt
    assign dest_addr = (opcode == OP_SPECIAL) ? instr[15:11] : instr[20:16];

    always_comb begin
        alu_op    = ALU_ADD;
        imm_ext   = IMM_NONE;
        shift_sel = 1'b0;
        reg_we    = 1'b0;
        dm_we     = 1'b0;
        wb_sel    = WB_ALU;

        case (opcode)
            OP_SPECIAL: begin
                reg_we = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    FN_SLL: begin
                        alu_op    = ALU_SLL;
                        shift_sel = 1'b1;      // shamt replaces rs
                    end
                    FN_SRL: begin
                        alu_op    = ALU_SRL;
                        shift_sel = 1'b1;
                    end
                    default: reg_we = 1'b0;  // Unknown funct is a no-op
                endcase
            end
            OP_ADDIU: begin
                reg_we  = 1'b1;
                imm_ext = IMM_SIGN;
            end
            OP_SLTI: begin
                reg_we  = 1'b1;
                alu_op  = ALU_SLT;
                imm_ext = IMM_SIGN;
            end
            OP_SLTIU: begin
                reg_we  = 1'b1;
                alu_op  = ALU_SLTU;
                imm_ext = IMM_ZERO;
            end
            OP_ANDI: begin
                reg_we  = 1'b1;
                alu_op  = ALU_AND;
                imm_ext = IMM_ZERO;
            end
            OP_ORI: begin
                reg_we  = 1'b1;
                alu_op  = ALU_OR;
                imm_ext = IMM_ZERO;
            end
            OP_XORI: begin
                reg_we  = 1'b1;
                alu_op  = ALU_XOR;
                imm_ext = IMM_ZERO;
            end
            OP_LUI: begin
                reg_we = 1'b1;
                wb_sel = WB_LUI;             // ALU result unused
            end
            // Loads and stores compute rs + sign-extended offset
            OP_LW: begin
                reg_we  = 1'b1;
                imm_ext = IMM_SIGN;
                wb_sel  = WB_MEM;
            end
            OP_SW: begin
                dm_we   = 1'b1;
                imm_ext = IMM_SIGN;
            end
            default: ;
        endcase
    end

endmodule

// ==== mpa_reg_file.sv ====
`timescale 1ns/1ns

module mpa_reg_file import mpa_pkg::*; (
    input  logic      mem_debug_clk_gate,
    input  logic      HW_RSTn,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  reg_addr_t wr_addr,
    input  logic      wr_en,
    input  word_t     wr_data,
    output word_t     rs_data,
    output word_t     rt_data
);

    word_t regs [REG_COUNT];

    always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
        if (!HW_RSTn) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // $zero reads as constant
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

// ==== mpa_execute.sv ====
`timescale 1ns/1ns

module mpa_execute import mpa_pkg::*; (
    input  instr_t   instr,
    input  word_t    rs_data,
    input  word_t    rt_data,
    input  alu_op_e  alu_op,
    input  imm_ext_e imm_ext,
    input  logic     shift_sel,
    output word_t    alu_result
);

    word_t       op_a;
    word_t       op_b;
    logic [15:0] imm;
    logic [4:0]  shamt;

    assign imm   = instr[15:0];
    assign shamt = instr[10:6];

    // Operand A
    assign op_a = shift_sel ? {{(DATA_W-5){1'b0}}, shamt} : rs_data;

    // Operand B, register or extended immediate
    always_comb begin
        case (imm_ext)
            IMM_SIGN: op_b = {{(DATA_W-16){imm[15]}}, imm};
            IMM_ZERO: op_b = {{(DATA_W-16){1'b0}}, imm};
            default:  op_b = rt_data;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            ALU_NOR: alu_result = ~(op_a | op_b);
            // Shift amount lives in A, value in B
            ALU_SLL: alu_result = op_b << op_a[4:0];
            ALU_SRL: alu_result = op_b >> op_a[4:0];
            ALU_SLT: begin
                alu_result = {{(DATA_W-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            end
            ALU_SLTU: begin
                alu_result = {{(DATA_W-1){1'b0}}, (op_a < op_b)};
            end
            default: alu_result = '0;
        endcase
    end

endmodule

// ==== mpa_mem_wb.sv ====
`timescale 1ns/1ns

module mpa_mem_wb import mpa_pkg::*; (
    input  logic      mem_debug_clk_gate,
    input  logic      mem_debug,
    input  logic      dm_dbg_we,
    input  logic      mr_dbg_we,
    input  word_t     addr,
    input  word_t     din,
    input  word_t     alu_result,
    input  word_t     rt_data,
    input  instr_t    instr,
    input  logic      reg_we,
    input  logic      dm_we,
    input  wb_sel_e   wb_sel,
    input  reg_addr_t dest_addr,
    output word_t     dm_rdata,
    output logic      wr_en,
    output reg_addr_t wr_addr,
    output word_t     wr_data
);

    logic [DM_AW-1:0] dm_idx;
    logic             dm_wr_en;
    word_t            dm_wdata;
    word_t            wb_data;

    // Debug port owns the data memory while mem_debug is high
    assign dm_idx   = mem_debug ? addr[DM_AW+1:2] : alu_result[DM_AW+1:2];
    assign dm_wr_en = mem_debug ? dm_dbg_we : dm_we;
    assign dm_wdata = mem_debug ? din : rt_data;

    mpa_word_ram #(
        .payload_t (word_t),
        .DEPTH     (DM_DEPTH)
    ) i_dmem (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .we                 (dm_wr_en),
        .waddr              (dm_idx),
        .raddr              (dm_idx),
        .wdata              (dm_wdata),
        .rdata              (dm_rdata)
    );

    always_comb begin
        case (wb_sel)
            WB_MEM:  wb_data = dm_rdata;
            WB_LUI:  wb_data = {instr[15:0], {(DATA_W-16){1'b0}}};
            default: wb_data = alu_result;
        endcase
    end

    assign wr_en   = mem_debug ? mr_dbg_we : reg_we;
    assign wr_addr = mem_debug ? addr[4:0] : dest_addr;
    assign wr_data = mem_debug ? din : wb_data;

endmodule

// ==== mpa_mips_x32.sv ====
`timescale 1ns/1ns

module mpa_mips_x32 import mpa_pkg::*; (
    input  logic       mem_debug_clk_gate,
    input  logic       HW_RSTn,
    input  word_t      din,
    input  word_t      addr,
    input  logic [1:0] debug_func,   // IM, DM, MR on codes 1 to 3
    input  logic       debug_we,
    input  logic       mem_debug,
    output word_t      dout
);

    instr_t    instr;
    reg_addr_t rs_addr, rt_addr, dest_addr;
    alu_op_e   alu_op;
    imm_ext_e  imm_ext;
    logic      shift_sel;
    logic      reg_we, dm_we;
    wb_sel_e   wb_sel;
    word_t     rs_data, rt_data;
    word_t     alu_result;
    word_t     dm_rdata;
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;
    logic      dbg_wr;
    logic      im_dbg_we, dm_dbg_we, mr_dbg_we;

    // Debug target decode, nothing lands while reset is asserted
    assign dbg_wr    = HW_RSTn && mem_debug && debug_we;
    assign im_dbg_we = dbg_wr && (debug_func == DBG_IM);
    assign dm_dbg_we = dbg_wr && (debug_func == DBG_DM);
    assign mr_dbg_we = dbg_wr && (debug_func == DBG_MR);

    mpa_fetch i_fetch (
        .mem_debug_clk_gate, .HW_RSTn, .mem_debug, .im_dbg_we, .addr, .din, .instr
    );

    mpa_decode i_decode (
        .instr, .mem_debug, .addr, .rs_addr, .rt_addr, .dest_addr,
        .alu_op, .imm_ext, .shift_sel, .reg_we, .dm_we, .wb_sel
    );

    mpa_reg_file i_reg_file (
        .mem_debug_clk_gate, .HW_RSTn, .rs_addr, .rt_addr,
        .wr_addr, .wr_en, .wr_data, .rs_data, .rt_data
    );

    mpa_execute i_execute (
        .instr, .rs_data, .rt_data, .alu_op, .imm_ext, .shift_sel, .alu_result
    );

    mpa_mem_wb i_mem_wb (
        .mem_debug_clk_gate, .mem_debug, .dm_dbg_we, .mr_dbg_we, .addr, .din,
        .alu_result, .rt_data, .instr, .reg_we,
        .dm_we     (dm_we && HW_RSTn),   // Blocks a stray SW at PC 0 during reset
        .wb_sel, .dest_addr, .dm_rdata, .wr_en, .wr_addr, .wr_data
    );

    // Read-back mux
    always_comb begin
        case (debug_func)
            DBG_IM:  dout = instr;      // Fetch reads at addr during debug
            DBG_DM:  dout = dm_rdata;
            DBG_MR:  dout = rt_data;
            default: dout = '0;
        endcase
    end

endmodule

// ==== tb_mpa_mips_x32.sv ====
`timescale 1ns/1ns

module tb_mpa_mips_x32 import mpa_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int PROG_LEN   = 32;

    logic       mem_debug_clk_gate = 1'b0;
    logic       HW_RSTn;
    word_t      din;
    word_t      addr;
    logic [1:0] debug_func;
    logic       debug_we;
    logic       mem_debug;
    word_t      dout;

    word_t  m_regs [REG_COUNT];   // Reference model
    word_t  m_dm   [DM_DEPTH];
    instr_t prog   [PROG_LEN];
    word_t  lcg_state   = 32'd21208;
    int     cycle_count = 0;
    int     checks      = 0;
    int     errors      = 0;

    mpa_mips_x32 i_mpa_mips_x32 (
        .mem_debug_clk_gate, .HW_RSTn, .din, .addr, .debug_func, .debug_we, .mem_debug, .dout
    );

    always #(CLK_PERIOD/2) mem_debug_clk_gate = ~mem_debug_clk_gate;

    always @(posedge mem_debug_clk_gate) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Upper halves of two draws, low LCG bits repeat quickly
    function automatic word_t rand32();
        word_t hi;
        word_t lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi[31:16], lo[31:16]};
    endfunction

    // Returns on a falling edge
    task automatic wait_cycles(input int n);
        int target;
        int guard;
        target = cycle_count + n;
        guard  = 0;
        while (cycle_count < target) begin
            @(negedge mem_debug_clk_gate);
            guard++;
            if (guard > n + 4) begin
                $display("Timeout: clock stopped while waiting for %0d cycles", n);
                $display("ERRORS FOUND");
                $finish;
            end
        end
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic debug_write(input logic [1:0] func, input word_t a, input word_t d);
        mem_debug  = 1'b1;
        debug_func = func;
        addr       = a;
        din        = d;
        debug_we   = 1'b1;
        wait_cycles(1);
        debug_we   = 1'b0;
    endtask

    task automatic debug_read(input logic [1:0] func, input word_t a, output word_t d);
        mem_debug  = 1'b1;
        debug_func = func;
        addr       = a;
        debug_we   = 1'b0;
        #(CLK_PERIOD/4);      // Mid low phase, dout settled
        d = dout;
        wait_cycles(1);
    endtask

    task automatic check_state(input bit with_dm);
        word_t got;
        for (int i = 0; i < REG_COUNT; i++) begin
            debug_read(DBG_MR, word_t'(i), got);
            check_value($sformatf("reg[%0d]", i), got, m_regs[i]);
        end
        for (int i = 0; with_dm && i < DM_DEPTH; i++) begin
            debug_read(DBG_DM, word_t'(i * 4), got);
            check_value($sformatf("dmem[%0d]", i), got, m_dm[i]);
        end
    endtask

    // Random registers and data memory, $zero gets a write it must ignore
    task automatic load_random_state();
        word_t d;
        for (int i = 0; i < REG_COUNT; i++) begin
            d = rand32();
            debug_write(DBG_MR, word_t'(i), d);
            m_regs[i] = (i == 0) ? '0 : d;
        end
        for (int i = 0; i < DM_DEPTH; i++) begin
            d = rand32();
            debug_write(DBG_DM, word_t'(i * 4), d);
            m_dm[i] = d;
        end
    endtask

    task automatic model_exec(input instr_t ins);
        logic [5:0] op, fn;
        logic [4:0] rs, rt, rd, sh, dst, widx;
        word_t      a, b, simm, zimm, eff, res;
        logic       wr;
        op   = ins[31:26];
        rs   = ins[25:21];
        rt   = ins[20:16];
        rd   = ins[15:11];
        sh   = ins[10:6];
        fn   = ins[5:0];
        a    = m_regs[rs];
        b    = m_regs[rt];
        simm = {{16{ins[15]}}, ins[15:0]};
        zimm = {16'h0000, ins[15:0]};
        eff  = a + simm;
        widx = eff[6:2];          // 32-word data memory
        res  = '0;
        wr   = 1'b1;
        dst  = rt;
        case (op)
            OP_SPECIAL: begin
                dst = rd;
                case (fn)
                    FN_ADDU: res = a + b;
                    FN_SUBU: res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_NOR:  res = ~(a | b);
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                    FN_SLL:  res = b << sh;
                    FN_SRL:  res = b >> sh;
                    default: wr = 1'b0;
                endcase
            end
            OP_ADDIU: res = a + simm;
            OP_SLTI:  res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            OP_SLTIU: res = (a < zimm) ? 32'd1 : 32'd0;
            OP_ANDI:  res = a & zimm;
            OP_ORI:   res = a | zimm;
            OP_XORI:  res = a ^ zimm;
            OP_LUI:   res = {ins[15:0], 16'h0000};
            OP_LW:    res = m_dm[widx];
            OP_SW: begin
                wr         = 1'b0;
                m_dm[widx] = b;
            end
            default:  wr = 1'b0;
        endcase
        if (wr && dst != 5'd0) begin
            m_regs[dst] = res;
        end
    endtask

    // Mode 0 R-type, 1 immediate, 2 mixed with LW and SW
    task automatic gen_instr(input int mode, input bit dest_zero, output instr_t ins);
        word_t      r, imm_r;
        logic [4:0] rs, rt, rd, sh, idx;
        logic [5:0] fn, op;
        int         kind;
        r     = rand32();
        imm_r = rand32();
        rs    = r[4:0];
        rt    = r[9:5];
        rd    = dest_zero ? 5'd0 : r[14:10];
        sh    = r[19:15];
        idx   = r[28:24];
        kind  = (mode == 2) ? int'(r[31:30]) : mode;
        case (int'(r[23:20]) % 10)
            0: fn = FN_ADDU;
            1: fn = FN_SUBU;
            2: fn = FN_AND;
            3: fn = FN_OR;
            4: fn = FN_XOR;
            5: fn = FN_NOR;
            6: fn = FN_SLT;
            7: fn = FN_SLTU;
            8: fn = FN_SLL;
            default: fn = FN_SRL;
        endcase
        case (int'(r[22:20]) % 7)
            0: op = OP_ADDIU;
            1: op = OP_SLTI;
            2: op = OP_SLTIU;
            3: op = OP_ANDI;
            4: op = OP_ORI;
            5: op = OP_XORI;
            default: op = OP_LUI;
        endcase
        if (dest_zero) begin
            rt = (kind == 0) ? rt : 5'd0;
        end
        case (kind)
            0: ins = {OP_SPECIAL, rs, rt, rd, sh, fn};
            1: ins = {op, rs, rt, imm_r[15:0]};
            2: ins = {OP_LW, 5'd0, rt, 9'd0, idx, 2'b00};   // Base $zero, word aligned
            default: ins = {OP_SW, 5'd0, rt, 9'd0, idx, 2'b00};
        endcase
    endtask

    task automatic run_phase(input int mode, input bit dest_zero);
        for (int i = 0; i < PROG_LEN; i++) begin
            gen_instr(mode, dest_zero, prog[i]);
            debug_write(DBG_IM, word_t'(i * 4), prog[i]);
        end
        mem_debug  = 1'b0;        // PC starts from the reset address
        debug_func = 2'd0;
        wait_cycles(PROG_LEN);
        mem_debug  = 1'b1;
        for (int i = 0; i < PROG_LEN; i++) begin
            model_exec(prog[i]);
        end
        check_state(1'b1);
    endtask

    initial begin
        word_t got;
        HW_RSTn    = 1'b0;
        mem_debug  = 1'b1;
        debug_we   = 1'b0;
        debug_func = 2'd0;
        addr       = '0;
        din        = '0;
        for (int i = 0; i < REG_COUNT; i++) begin
            m_regs[i] = '0;
        end
        wait_cycles(5);
        HW_RSTn = 1'b1;
        wait_cycles(1);

        check_state(1'b0);

        // Instruction memory round trip
        for (int i = 0; i < IM_DEPTH; i++) begin
            prog[i] = rand32();
            debug_write(DBG_IM, word_t'(i * 4), prog[i]);
        end
        for (int i = 0; i < IM_DEPTH; i++) begin
            debug_read(DBG_IM, word_t'(i * 4), got);
            check_value($sformatf("imem[%0d]", i), got, prog[i]);
        end
        debug_read(2'd0, word_t'(8), got);
        check_value("dout with debug_func 0", got, '0);

        load_random_state();
        check_state(1'b1);

        run_phase(0, 1'b0);
        load_random_state();
        run_phase(1, 1'b0);
        load_random_state();
        run_phase(2, 1'b0);
        run_phase(2, 1'b1);       // Every destination is $zero

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== list.f ====
mpa_pkg.sv
mpa_word_ram.sv
mpa_fetch.sv
mpa_decode.sv
mpa_reg_file.sv
mpa_execute.sv
mpa_mem_wb.sv
mpa_mips_x32.sv
tb_mpa_mips_x32.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mpa_mips_x32
RTL_TOP   ?= mpa_mips_x32
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= NO ERRORS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
